//--- build.f
+incdir+.
cpu_pkg.sv
stage_reg.sv
alu.sv
fetch_decode.sv
execute_unit.sv
mem_writeback.sv
cpu_core.sv
cpu_core_props.sv
tb_cpu_core.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - stage_reg.sv
      - alu.sv
      - fetch_decode.sv
      - execute_unit.sv
      - mem_writeback.sv
      - cpu_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - cpu_core_props.sv
      - tb_cpu_core.sv

//--- tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module tb_cpu_core;

    // One program word with the register write it should cause
    typedef struct packed {
        logic [31:0] insn;
        logic        wr;
        logic [4:0]  rd;
        logic [31:0] value;
    } row_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    logic        clock = 1'b0;
    logic        rst_n;
    logic [31:0] address_imem;
    logic [31:0] q_imem;
    logic [31:0] address_dmem;
    logic [31:0] data;
    logic        wren;
    logic [31:0] q_dmem;
    logic        ctrl_write_enable;
    logic [4:0]  ctrl_write_reg;
    logic [4:0]  ctrl_read_reg_a;
    logic [4:0]  ctrl_read_reg_b;
    logic [31:0] data_write_reg;
    logic [31:0] data_read_reg_a;
    logic [31:0] data_read_reg_b;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] regs [32];
    row_t        prog [256];
    int          n_rows = 0;
    int          exp_order [$];
    store_t      exp_stores [$];
    int          wr_idx = 0;
    int          st_idx = 0;
    int          cycles = 0;
    int          limit = 0;

    cpu_core DUT (.*);

    always #4 clock = ~clock;

    // Memories and register file answer in the same cycle
    assign q_imem = imem[address_imem[7:0]];
    assign q_dmem = dmem[address_dmem[7:0]];
    assign data_read_reg_a = (ctrl_read_reg_a == '0) ? '0 : regs[ctrl_read_reg_a];
    assign data_read_reg_b = (ctrl_read_reg_b == '0) ? '0 : regs[ctrl_read_reg_b];

    always @(posedge clock) begin
        if (ctrl_write_enable) begin
            regs[ctrl_write_reg] <= data_write_reg;
        end
        if (wren) begin
            dmem[address_dmem[7:0]] <= data;
        end
    end

    function automatic logic [31:0] fill_word(input int i);
        return {8'hd0, i[7:0], ~i[7:0], i[7:0] ^ 8'h5a};
    endfunction

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] r_op(input logic [4:0] fn, rd, rs, rt, sh);
        return {`CPU_OP_RTYPE, rd, rs, rt, sh, fn, 2'b00};
    endfunction

    function automatic logic [31:0] i_op(input logic [4:0] op, rd, rs, input logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic logic [31:0] j_op(input logic [4:0] op, input int target);
        return {op, target[26:0]};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic put(input logic [31:0] w);
        prog[n_rows].insn = w;
        n_rows++;
    endtask

    task automatic build_program();
        logic [31:0] seed;
        int          p;
        seed = 32'hc94e;
        seed = lcg(seed);
        put(i_op(`CPU_OP_ADDI, 5'd1, 5'd0, seed[30:14]));
        seed = lcg(seed);
        put(i_op(`CPU_OP_ADDI, 5'd2, 5'd1, seed[30:14]));
        // Each source one back (X/M) and two back (writeback)
        put(r_op(`CPU_ALU_ADD, 5'd3, 5'd1, 5'd2, 5'd0));
        put(r_op(`CPU_ALU_SUB, 5'd4, 5'd3, 5'd2, 5'd0));
        put(r_op(`CPU_ALU_AND, 5'd5, 5'd4, 5'd3, 5'd0));
        put(r_op(`CPU_ALU_OR, 5'd6, 5'd5, 5'd4, 5'd0));
        put(r_op(`CPU_ALU_SLL, 5'd7, 5'd6, 5'd0, 5'd3));
        put(r_op(`CPU_ALU_SRA, 5'd8, 5'd7, 5'd0, 5'd2));
        put(r_op(`CPU_ALU_ADD, 5'd9, 5'd8, 5'd6, 5'd0));
        // Store then load, load-use stall, load feeding store data
        put(i_op(`CPU_OP_SW, 5'd3, 5'd0, 17'd4));
        put(i_op(`CPU_OP_LW, 5'd10, 5'd0, 17'd4));
        put(r_op(`CPU_ALU_ADD, 5'd11, 5'd10, 5'd10, 5'd0));
        put(i_op(`CPU_OP_LW, 5'd12, 5'd0, 17'd20));
        put(i_op(`CPU_OP_SW, 5'd12, 5'd0, 17'd21));
        put(i_op(`CPU_OP_LW, 5'd13, 5'd0, 17'd21));
        put(i_op(`CPU_OP_ADDI, 5'd14, 5'd13, 17'h1ffff));
        put(i_op(`CPU_OP_ADDI, 5'd15, 5'd9, 17'd77));
        put(i_op(`CPU_OP_SW, 5'd15, 5'd0, 17'd30));
        put(i_op(`CPU_OP_LW, 5'd16, 5'd0, 17'd30));
        // Branches taken and not taken, shadows must not write
        put(i_op(`CPU_OP_ADDI, 5'd17, 5'd0, 17'd5));
        put(i_op(`CPU_OP_ADDI, 5'd18, 5'd0, 17'h1fffd));
        put(i_op(`CPU_OP_BNE, 5'd18, 5'd17, 17'd2));
        put(i_op(`CPU_OP_ADDI, 5'd20, 5'd0, 17'd1));
        put(i_op(`CPU_OP_ADDI, 5'd21, 5'd0, 17'd2));
        put(i_op(`CPU_OP_BNE, 5'd17, 5'd17, 17'd2));
        put(i_op(`CPU_OP_ADDI, 5'd22, 5'd0, 17'd3));
        put(i_op(`CPU_OP_BLT, 5'd18, 5'd17, 17'd2));
        put(i_op(`CPU_OP_ADDI, 5'd23, 5'd0, 17'd6));
        put(i_op(`CPU_OP_ADDI, 5'd24, 5'd0, 17'd7));
        put(i_op(`CPU_OP_BLT, 5'd17, 5'd18, 17'd2));
        put(i_op(`CPU_OP_ADDI, 5'd25, 5'd22, 17'd4));
        put(j_op(`CPU_OP_J, n_rows + 3));
        put(i_op(`CPU_OP_ADDI, 5'd26, 5'd0, 17'd8));
        put(i_op(`CPU_OP_ADDI, 5'd27, 5'd0, 17'd9));
        // Call a two-word routine and return through r31
        p = n_rows;
        put(j_op(`CPU_OP_JAL, p + 3));
        put(i_op(`CPU_OP_ADDI, 5'd28, `CPU_REG_RA, 17'd0));
        put(j_op(`CPU_OP_J, p + 6));
        put(i_op(`CPU_OP_ADDI, 5'd29, 5'd0, 17'd9));
        put(i_op(`CPU_OP_JR, `CPU_REG_RA, 5'd0, 17'd0));
        put(i_op(`CPU_OP_ADDI, 5'd30, 5'd0, 17'd11));
        put(r_op(`CPU_ALU_ADD, 5'd19, `CPU_REG_RA, 5'd29, 5'd0));
    endtask

    // Walks the program in execution order and records every row it executes
    task automatic run_model();
        logic [31:0]    r [32];
        logic [31:0]    mem [256];
        logic [31:0]    pc;
        logic [31:0]    next;
        logic [31:0]    imm;
        logic [31:0]    res;
        logic [4:0]     dst;
        store_t         st;
        cpu_pkg::insn_t f;
        int             steps;
        for (int i = 0; i < 32; i++) r[i] = '0;
        for (int i = 0; i < 256; i++) mem[i] = fill_word(i);
        pc = '0;
        steps = 0;
        while (pc < n_rows && steps < 1000) begin
            f = cpu_pkg::insn_t'(prog[pc].insn);
            imm = {{15{prog[pc].insn[16]}}, prog[pc].insn[16:0]};
            next = pc + 1;
            dst = '0;
            res = '0;
            case (f.opcode)
                `CPU_OP_RTYPE: begin
                    dst = f.rd;
                    case (f.alu_op)
                        `CPU_ALU_ADD: res = r[f.rs] + r[f.rt];
                        `CPU_ALU_SUB: res = r[f.rs] - r[f.rt];
                        `CPU_ALU_AND: res = r[f.rs] & r[f.rt];
                        `CPU_ALU_OR:  res = r[f.rs] | r[f.rt];
                        `CPU_ALU_SLL: res = r[f.rs] << f.shamt;
                        `CPU_ALU_SRA: res = $signed(r[f.rs]) >>> f.shamt;
                        default:      res = '0;
                    endcase
                end
                `CPU_OP_ADDI: begin
                    dst = f.rd;
                    res = r[f.rs] + imm;
                end
                `CPU_OP_LW: begin
                    dst = f.rd;
                    st.addr = r[f.rs] + imm;
                    res = mem[st.addr[7:0]];
                end
                `CPU_OP_SW: begin
                    st.addr = r[f.rs] + imm;
                    st.data = r[f.rd];
                    mem[st.addr[7:0]] = st.data;
                    exp_stores.push_back(st);
                end
                `CPU_OP_J: next = {{5{prog[pc].insn[26]}}, prog[pc].insn[26:0]};
                `CPU_OP_JAL: begin
                    dst = `CPU_REG_RA;
                    res = pc + 1;
                    next = {{5{prog[pc].insn[26]}}, prog[pc].insn[26:0]};
                end
                `CPU_OP_JR: next = r[f.rd];
                `CPU_OP_BNE: if (r[f.rs] != r[f.rd]) next = pc + 1 + imm;
                `CPU_OP_BLT: if ($signed(r[f.rd]) < $signed(r[f.rs])) next = pc + 1 + imm;
                default: next = pc + 1;
            endcase
            if (dst != '0) begin
                r[dst] = res;
                prog[pc].wr = 1'b1;
                prog[pc].rd = dst;
                prog[pc].value = res;
            end
            exp_order.push_back(int'(pc));
            pc = next;
            steps++;
        end
    endtask

    // Writes and stores must retire in program order
    always @(posedge clock) begin
        if (rst_n) begin
            cycles++;
            // Executed rows with a cleared flag retire without a register write
            while (wr_idx < exp_order.size() && !prog[exp_order[wr_idx]].wr) begin
                wr_idx++;
            end
            if (cycles > limit) begin
                fail_run($sformatf("Timeout: program did not finish within %0d cycles", limit));
            end else if (ctrl_write_enable && wr_idx >= exp_order.size()) begin
                fail_run($sformatf("Unexpected register write to r%0d", ctrl_write_reg));
            end else if (wren && st_idx >= exp_stores.size()) begin
                fail_run("Unexpected store to data memory");
            end else begin
                if (ctrl_write_enable) begin
                    check("ctrl_write_reg", 32'(ctrl_write_reg), 32'(prog[exp_order[wr_idx]].rd));
                    check("data_write_reg", data_write_reg, prog[exp_order[wr_idx]].value);
                    wr_idx++;
                end
                if (wren) begin
                    check("address_dmem", address_dmem, exp_stores[st_idx].addr);
                    check("data", data, exp_stores[st_idx].data);
                    st_idx++;
                end
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = fill_word(i);
            prog[i] = '0;
        end
        for (int i = 0; i < 32; i++) regs[i] = '0;
        build_program();
        run_model();
        for (int i = 0; i < n_rows; i++) imem[i] = prog[i].insn;
        limit = 4 * n_rows + 40;
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        wait (wr_idx == exp_order.size() && st_idx == exp_stores.size());
        // A few more cycles to catch stray writes from the flushed shadows
        repeat (8) @(posedge clock);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- cpu_core_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_core_props (
    input logic                  clock,
    input logic                  rst_n,
    input logic [`CPU_XLEN-1:0]  address_imem,
    input logic                  wren,
    input logic                  ctrl_write_enable,
    input logic [`CPU_REG_W-1:0] ctrl_write_reg,
    input logic                  redirect_taken
);

    // Latches clear on the first reset edge, so look one cycle on
    reset_quiet: assert property (@(posedge clock) !rst_n |=> !wren && !ctrl_write_enable)
        else $error("write strobe active while in reset");

    no_write_r0: assert property (@(posedge clock) disable iff (!rst_n)
        ctrl_write_enable |-> ctrl_write_reg != '0)
        else $error("register write aimed at r0");

    // A load-use stall holds the PC for one cycle
    pc_steps: assert property (@(posedge clock) disable iff (!rst_n)
        !redirect_taken |=> (address_imem == $past(address_imem) + 1) ||
                            (address_imem == $past(address_imem)))
        else $error("fetch address jumped without a redirect");

endmodule

bind cpu_core cpu_core_props u_props (
    .clock             (clock),
    .rst_n             (rst_n),
    .address_imem      (address_imem),
    .wren              (wren),
    .ctrl_write_enable (ctrl_write_enable),
    .ctrl_write_reg    (ctrl_write_reg),
    .redirect_taken    (redirect.taken)
);

`default_nettype wire

//--- cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_core (
    input  logic                  clock,
    input  logic                  rst_n,
    output logic [`CPU_XLEN-1:0]  address_imem,
    input  logic [`CPU_XLEN-1:0]  q_imem,
    output logic [`CPU_XLEN-1:0]  address_dmem,
    output logic [`CPU_XLEN-1:0]  data,
    output logic                  wren,
    input  logic [`CPU_XLEN-1:0]  q_dmem,
    output logic                  ctrl_write_enable,
    output logic [`CPU_REG_W-1:0] ctrl_write_reg,
    output logic [`CPU_REG_W-1:0] ctrl_read_reg_a,
    output logic [`CPU_REG_W-1:0] ctrl_read_reg_b,
    output logic [`CPU_XLEN-1:0]  data_write_reg,
    input  logic [`CPU_XLEN-1:0]  data_read_reg_a,
    input  logic [`CPU_XLEN-1:0]  data_read_reg_b
);

    cpu_pkg::redirect_t redirect;
    cpu_pkg::wb_t       wb;
    cpu_pkg::dx_t       dx;
    cpu_pkg::xm_t       xm;

    fetch_decode u_fetch_decode (
        .clock           (clock),
        .rst_n           (rst_n),
        .redirect        (redirect),
        .wb              (wb),
        .address_imem    (address_imem),
        .q_imem          (q_imem),
        .ctrl_read_reg_a (ctrl_read_reg_a),
        .ctrl_read_reg_b (ctrl_read_reg_b),
        .data_read_reg_a (data_read_reg_a),
        .data_read_reg_b (data_read_reg_b),
        .dx              (dx)
    );

    execute_unit u_execute_unit (
        .clock    (clock),
        .rst_n    (rst_n),
        .dx       (dx),
        .wb       (wb),
        .redirect (redirect),
        .xm       (xm)
    );

    mem_writeback u_mem_writeback (
        .clock        (clock),
        .rst_n        (rst_n),
        .xm           (xm),
        .address_dmem (address_dmem),
        .data         (data),
        .wren         (wren),
        .q_dmem       (q_dmem),
        .wb           (wb)
    );

    // Register file write port
    assign ctrl_write_enable = wb.wr_en;
    assign ctrl_write_reg    = wb.rd;
    assign data_write_reg    = wb.data;

endmodule

`default_nettype wire

//--- mem_writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module mem_writeback (
    input  logic                 clock,
    input  logic                 rst_n,
    input  cpu_pkg::xm_t         xm,
    output logic [`CPU_XLEN-1:0] address_dmem,
    output logic [`CPU_XLEN-1:0] data,
    output logic                 wren,
    input  logic [`CPU_XLEN-1:0] q_dmem,
    output cpu_pkg::wb_t         wb
);

    logic                 is_store;
    cpu_pkg::mw_t         mw_d;
    cpu_pkg::mw_t         mw;

    assign is_store     = (xm.insn.opcode == `CPU_OP_SW);
    assign address_dmem = xm.result;
    assign wren         = is_store;

    // Store data written by the instruction one ahead, incl. a load
    assign data = (is_store && wb.wr_en && wb.rd == xm.insn.rd) ? wb.data : xm.store;

    assign mw_d.insn   = xm.insn;
    assign mw_d.result = xm.result;
    assign mw_d.load   = q_dmem;

    stage_reg #(.payload_t(cpu_pkg::mw_t)) u_mw_reg (
        .clock  (clock),
        .rst_n  (rst_n),
        .en     (1'b1),
        .bubble (1'b0),
        .d      (mw_d),
        .q      (mw)
    );

    // Destination is zero for anything that writes no register
    assign wb.rd    = cpu_pkg::dest(mw.insn);
    assign wb.wr_en = (wb.rd != '0);
    assign wb.data  = (mw.insn.opcode == `CPU_OP_LW) ? mw.load : mw.result;

endmodule

`default_nettype wire

//--- execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module execute_unit (
    input  logic               clock,
    input  logic               rst_n,
    input  cpu_pkg::dx_t       dx,
    input  cpu_pkg::wb_t       wb,
    output cpu_pkg::redirect_t redirect,
    output cpu_pkg::xm_t       xm
);

    logic [`CPU_XLEN-1:0]  insn_bits;
    logic [`CPU_OPC_W-1:0] opcode;
    logic [`CPU_REG_W-1:0] reg_a;
    logic [`CPU_REG_W-1:0] reg_b;
    logic [`CPU_REG_W-1:0] xm_dest;
    logic [`CPU_XLEN-1:0]  op_a;
    logic [`CPU_XLEN-1:0]  op_b;
    logic [`CPU_XLEN-1:0]  imm;
    logic [`CPU_XLEN-1:0]  jump_target;
    logic                  use_imm;
    logic [`CPU_ALU_W-1:0] alu_func;
    logic [`CPU_XLEN-1:0]  alu_result;
    logic                  alu_ne;
    logic                  alu_lt;
    cpu_pkg::xm_t          xm_d;

    assign insn_bits = dx.insn;
    assign opcode    = dx.insn.opcode;
    assign reg_a     = cpu_pkg::src_a(dx.insn);
    assign reg_b     = cpu_pkg::src_b(dx.insn);
    assign xm_dest   = cpu_pkg::dest(xm.insn);

    // Younger result in X/M beats writeback, r0 never matches
    always_comb begin
        if (xm_dest != '0 && xm_dest == reg_a) begin
            op_a = xm.result;
        end else if (wb.wr_en && wb.rd == reg_a) begin
            op_a = wb.data;
        end else begin
            op_a = dx.a;
        end
        if (xm_dest != '0 && xm_dest == reg_b) begin
            op_b = xm.result;
        end else if (wb.wr_en && wb.rd == reg_b) begin
            op_b = wb.data;
        end else begin
            op_b = dx.b;
        end
    end

    assign imm         = {{(`CPU_XLEN-17){insn_bits[16]}}, insn_bits[16:0]};
    assign jump_target = {{(`CPU_XLEN-27){insn_bits[26]}}, insn_bits[26:0]};

    assign use_imm = (opcode == `CPU_OP_ADDI) || (opcode == `CPU_OP_LW) ||
                     (opcode == `CPU_OP_SW);

    always_comb begin
        case (opcode)
            `CPU_OP_ADDI, `CPU_OP_LW, `CPU_OP_SW: alu_func = `CPU_ALU_ADD;
            `CPU_OP_BNE, `CPU_OP_BLT:            alu_func = `CPU_ALU_SUB;
            default:                             alu_func = dx.insn.alu_op;
        endcase
    end

    alu u_alu (
        .a         (op_a),
        .b         (use_imm ? imm : op_b),
        .alu_op    (alu_func),
        .shamt     (dx.insn.shamt),
        .result    (alu_result),
        .not_equal (alu_ne),
        .less_than (alu_lt)
    );

    // blt is taken when rd < rs, that is b < a
    always_comb begin
        redirect.taken  = 1'b0;
        redirect.target = jump_target;
        case (opcode)
            `CPU_OP_BNE: begin
                redirect.taken  = alu_ne;
                redirect.target = dx.pc_next + imm;
            end
            `CPU_OP_BLT: begin
                redirect.taken  = alu_ne && !alu_lt;
                redirect.target = dx.pc_next + imm;
            end
            `CPU_OP_J, `CPU_OP_JAL: redirect.taken = 1'b1;
            `CPU_OP_JR: begin
                redirect.taken  = 1'b1;
                redirect.target = op_b;
            end
            default: redirect.taken = 1'b0;
        endcase
    end

    assign xm_d.insn   = dx.insn;
    assign xm_d.result = (opcode == `CPU_OP_JAL) ? dx.pc_next : alu_result;
    assign xm_d.store  = op_b;

    stage_reg #(.payload_t(cpu_pkg::xm_t)) u_xm_reg (
        .clock  (clock),
        .rst_n  (rst_n),
        .en     (1'b1),
        .bubble (1'b0),
        .d      (xm_d),
        .q      (xm)
    );

endmodule

`default_nettype wire

//--- fetch_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module fetch_decode (
    input  logic                       clock,
    input  logic                       rst_n,
    input  cpu_pkg::redirect_t         redirect,
    input  cpu_pkg::wb_t               wb,
    output logic [`CPU_XLEN-1:0]       address_imem,
    input  logic [`CPU_XLEN-1:0]       q_imem,
    output logic [`CPU_REG_W-1:0]      ctrl_read_reg_a,
    output logic [`CPU_REG_W-1:0]      ctrl_read_reg_b,
    input  logic [`CPU_XLEN-1:0]       data_read_reg_a,
    input  logic [`CPU_XLEN-1:0]       data_read_reg_b,
    output cpu_pkg::dx_t               dx
);

    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] pc_plus_one;
    cpu_pkg::fd_t         fd_d;
    cpu_pkg::fd_t         fd;
    cpu_pkg::dx_t         dx_d;
    logic                 load_in_dx;
    logic                 uses_a;
    logic                 uses_b;
    logic                 stall;

    assign pc_plus_one  = pc + 1'b1;
    assign address_imem = pc;

    // Redirect wins over the stall, the two never meet in the same cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (redirect.taken) begin
            pc <= redirect.target;
        end else if (!stall) begin
            pc <= pc_plus_one;
        end
    end

    assign fd_d.pc_next = pc_plus_one;
    assign fd_d.insn    = cpu_pkg::insn_t'(q_imem);

    stage_reg #(.payload_t(cpu_pkg::fd_t)) u_fd_reg (
        .clock  (clock),
        .rst_n  (rst_n),
        .en     (!stall),
        .bubble (redirect.taken),
        .d      (fd_d),
        .q      (fd)
    );

    assign ctrl_read_reg_a = cpu_pkg::src_a(fd.insn);
    assign ctrl_read_reg_b = cpu_pkg::src_b(fd.insn);

    // Register file writes on the edge, so a same-cycle write is taken from wb
    always_comb begin
        dx_d.pc_next = fd.pc_next;
        dx_d.insn    = fd.insn;
        dx_d.a = (wb.wr_en && wb.rd == ctrl_read_reg_a) ? wb.data : data_read_reg_a;
        dx_d.b = (wb.wr_en && wb.rd == ctrl_read_reg_b) ? wb.data : data_read_reg_b;
    end

    // Source use for the load-use test
    // sw data is left out since memory picks it up from writeback
    always_comb begin
        case (fd.insn.opcode)
            `CPU_OP_RTYPE, `CPU_OP_ADDI, `CPU_OP_LW, `CPU_OP_SW,
            `CPU_OP_BNE, `CPU_OP_BLT, `CPU_OP_JR: uses_a = 1'b1;
            default: uses_a = 1'b0;
        endcase
        case (fd.insn.opcode)
            `CPU_OP_RTYPE, `CPU_OP_BNE, `CPU_OP_BLT, `CPU_OP_JR: uses_b = 1'b1;
            default: uses_b = 1'b0;
        endcase
    end

    assign load_in_dx = (dx.insn.opcode == `CPU_OP_LW) && (dx.insn.rd != '0);
    assign stall = load_in_dx &&
                   ((uses_a && ctrl_read_reg_a == dx.insn.rd) ||
                    (uses_b && ctrl_read_reg_b == dx.insn.rd));

    stage_reg #(.payload_t(cpu_pkg::dx_t)) u_dx_reg (
        .clock  (clock),
        .rst_n  (rst_n),
        .en     (1'b1),
        .bubble (redirect.taken || stall),
        .d      (dx_d),
        .q      (dx)
    );

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module alu (
    input  logic [`CPU_XLEN-1:0]  a,
    input  logic [`CPU_XLEN-1:0]  b,
    input  logic [`CPU_ALU_W-1:0] alu_op,
    input  logic [`CPU_REG_W-1:0] shamt,
    output logic [`CPU_XLEN-1:0]  result,
    output logic                  not_equal,
    output logic                  less_than
);

    logic [`CPU_XLEN-1:0] sum;
    logic [`CPU_XLEN-1:0] diff;

    assign sum  = a + b;
    assign diff = a - b;

    // Signed compare from the difference
    // when signs differ the sign of a decides, since diff may overflow
    assign not_equal = |diff;
    assign less_than = (a[`CPU_XLEN-1] != b[`CPU_XLEN-1]) ? a[`CPU_XLEN-1]
                                                          : diff[`CPU_XLEN-1];

    always_comb begin
        case (alu_op)
            `CPU_ALU_ADD: result = sum;
            `CPU_ALU_SUB: result = diff;
            `CPU_ALU_AND: result = a & b;
            `CPU_ALU_OR:  result = a | b;
            `CPU_ALU_SLL: result = a << shamt;
            `CPU_ALU_SRA: result = $signed(a) >>> shamt;
            default:      result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     en,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // An all-zero payload decodes as add r0,r0,r0
    always_ff @(posedge clock) begin
        if (!rst_n || bubble) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

    // Immediate is {rt, shamt, alu_op, spare}, jump target is bits 26..0
    typedef struct packed {
        logic [`CPU_OPC_W-1:0] opcode;
        logic [`CPU_REG_W-1:0] rd;
        logic [`CPU_REG_W-1:0] rs;
        logic [`CPU_REG_W-1:0] rt;
        logic [`CPU_REG_W-1:0] shamt;
        logic [`CPU_ALU_W-1:0] alu_op;
        logic [1:0]            spare;
    } insn_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc_next;
        insn_t                insn;
    } fd_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc_next;
        insn_t                insn;
        logic [`CPU_XLEN-1:0] a;
        logic [`CPU_XLEN-1:0] b;
    } dx_t;

    typedef struct packed {
        insn_t                insn;
        logic [`CPU_XLEN-1:0] result;
        logic [`CPU_XLEN-1:0] store;
    } xm_t;

    typedef struct packed {
        insn_t                insn;
        logic [`CPU_XLEN-1:0] result;
        logic [`CPU_XLEN-1:0] load;
    } mw_t;

    typedef struct packed {
        logic                 wr_en;
        logic [`CPU_REG_W-1:0] rd;
        logic [`CPU_XLEN-1:0] data;
    } wb_t;

    typedef struct packed {
        logic                 taken;
        logic [`CPU_XLEN-1:0] target;
    } redirect_t;

    // jr reads its jump register through port a
    function automatic logic [`CPU_REG_W-1:0] src_a(insn_t insn);
        return (insn.opcode == `CPU_OP_JR) ? insn.rd : insn.rs;
    endfunction

    function automatic logic [`CPU_REG_W-1:0] src_b(insn_t insn);
        case (insn.opcode)
            `CPU_OP_SW, `CPU_OP_BNE, `CPU_OP_BLT, `CPU_OP_JR: return insn.rd;
            default: return insn.rt;
        endcase
    endfunction

    // Register written by the instruction, zero when it writes none
    function automatic logic [`CPU_REG_W-1:0] dest(insn_t insn);
        case (insn.opcode)
            `CPU_OP_RTYPE, `CPU_OP_ADDI, `CPU_OP_LW: return insn.rd;
            `CPU_OP_JAL: return `CPU_REG_RA;
            default: return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Widths
`define CPU_XLEN   32
`define CPU_REG_W  5
`define CPU_OPC_W  5
`define CPU_ALU_W  5

// Opcodes in insn[31:27]
`define CPU_OP_RTYPE 5'd0
`define CPU_OP_J     5'd1
`define CPU_OP_BNE   5'd2
`define CPU_OP_JAL   5'd3
`define CPU_OP_JR    5'd4
`define CPU_OP_ADDI  5'd5
`define CPU_OP_BLT   5'd6
`define CPU_OP_SW    5'd7
`define CPU_OP_LW    5'd8

// ALU function codes in insn[6:2]
`define CPU_ALU_ADD 5'd0
`define CPU_ALU_SUB 5'd1
`define CPU_ALU_AND 5'd2
`define CPU_ALU_OR  5'd3
`define CPU_ALU_SLL 5'd4
`define CPU_ALU_SRA 5'd5

// Link register written by jal
`define CPU_REG_RA 5'd31

`endif
